// ==== dnRegPkg.sv ====
package dnRegPkg;

    // ==============================
    // widths
    // ==============================
    localparam int regAddrW = 16;                  // host register address
    localparam int regDataW = 32;                  // host register data
    localparam int bufAddrW = 64;                  // buffer base address
    localparam int bufSizeW = 24;                  // transfer size
    localparam int dcntW    = 9;                   // full-buffer write-data count

    // ==============================
    // address map
    // ==============================
    localparam int chanBit    = 12;                // channel select
    localparam int ebufBit    = 8;                 // empty-buffer group select
    localparam int wordIdxLsb = 3;                 // 64-bit word spacing
    localparam int wordIdxW   = 2;

    localparam logic [wordIdxW-1:0] addrLoIdx = 2'd0;   // address bits 31..0
    localparam logic [wordIdxW-1:0] addrHiIdx = 2'd1;   // address bits 63..32
    localparam logic [wordIdxW-1:0] ctlIdx    = 2'd2;   // size and control bits
    localparam logic [wordIdxW-1:0] dcntIdx   = 2'd3;   // full buffer only

    // control-word bit positions
    localparam int trigBit = 24;
    localparam int reqBit  = 25;
    localparam int autoBit = 26;

    // the same control word seen by the full-buffer and the empty-buffer group
    typedef union packed {
        struct packed {
            logic [regDataW-autoBit-2:0] rsvd;     // bits 31..27
            logic                        autoFlag; // auto read mode
            logic                        req;      // read request pulse
            logic                        trig;     // read trigger pulse
            logic [bufSizeW-1:0]         size;
        } fbuf;
        struct packed {
            logic [regDataW-trigBit-2:0] rsvd;     // bits 31..25
            logic                        trig;     // write trigger pulse
            logic [bufSizeW-1:0]         size;
        } ebuf;
    } regWord_u;

endpackage

// ==== regAccessIf.sv ====
`timescale 1ns/1ns

// one decoded host access, valid in the cycle after the request
interface regAccessIf;

    logic                                  wrEn;    // write strobe
    logic                                  rdEn;    // read strobe
    logic                                  chanSel; // address bit 12
    logic                                  ebufSel; // address bit 8
    logic [dnRegPkg::wordIdxW-1:0]         wordIdx; // word within group
    logic                                  addrHit; // mapped location
    dnRegPkg::regWord_u                    wrWord;  // captured write data

    modport frontEnd (
        output wrEn, rdEn, chanSel, ebufSel, wordIdx, addrHit, wrWord
    );

    modport channel (
        input wrEn, rdEn, chanSel, ebufSel, wordIdx, addrHit, wrWord
    );

endinterface

// ==== dnRegFrontEnd.sv ====
`timescale 1ns/1ns

module dnRegFrontEnd (
    input  logic                            PCIE_CLK,
    input  logic                            PCIE_RST,
    input  logic                            regWrReq,
    input  logic                            regRdReq,
    input  logic [dnRegPkg::regDataW-1:0]   regWrData,
    input  logic [dnRegPkg::regAddrW-1:0]   regOpAddr,
    output logic                            regWrAck,
    regAccessIf.frontEnd                    acc
);

    logic                          wrEnQ;
    logic                          rdEnQ;
    logic [dnRegPkg::regAddrW-1:0] addrQ;
    dnRegPkg::regWord_u            dataQ;
    logic [dnRegPkg::regAddrW-1:0] spareBits;  // address bits outside the map fields
    logic                          ebufSel;
    logic [dnRegPkg::wordIdxW-1:0] wordIdx;

    // ==============================
    // request capture
    // ==============================
    always_ff @(posedge PCIE_CLK or posedge PCIE_RST) begin
        if (PCIE_RST) begin
            wrEnQ <= 1'b0;
            rdEnQ <= 1'b0;
            addrQ <= '0;
        end else begin
            wrEnQ <= regWrReq;
            rdEnQ <= regRdReq;
            if (regWrReq || regRdReq) begin
                addrQ <= regOpAddr;               // held until the next request
            end
        end
    end

    always_ff @(posedge PCIE_CLK) begin
        if (regWrReq) begin
            dataQ <= regWrData;
        end
    end

    // ==============================
    // address decode
    // ==============================
    assign ebufSel = addrQ[dnRegPkg::ebufBit];
    assign wordIdx = addrQ[dnRegPkg::wordIdxLsb +: dnRegPkg::wordIdxW];

    always_comb begin
        spareBits = addrQ;
        spareBits[dnRegPkg::chanBit] = 1'b0;
        spareBits[dnRegPkg::ebufBit] = 1'b0;
        spareBits[dnRegPkg::wordIdxLsb +: dnRegPkg::wordIdxW] = '0;
    end

    assign acc.wrEn    = wrEnQ;
    assign acc.rdEn    = rdEnQ;
    assign acc.chanSel = addrQ[dnRegPkg::chanBit];
    assign acc.ebufSel = ebufSel;
    assign acc.wordIdx = wordIdx;
    assign acc.wrWord  = dataQ;
    // empty-buffer group has no count word
    assign acc.addrHit = (spareBits == '0) && !(ebufSel && (wordIdx == dnRegPkg::dcntIdx));

    always_ff @(posedge PCIE_CLK or posedge PCIE_RST) begin
        if (PCIE_RST) begin
            regWrAck <= 1'b0;
        end else begin
            regWrAck <= wrEnQ;                    // every write acked, mapped or not
        end
    end

endmodule

// ==== dnChannelRegs.sv ====
`timescale 1ns/1ns

module dnChannelRegs #(
    parameter int chanId = 0
) (
    input  logic                            PCIE_CLK,
    input  logic                            PCIE_RST,
    regAccessIf.channel                     acc,
    input  logic [dnRegPkg::dcntW-1:0]      fbufWrDcnt,
    output logic                            fbufRdReq,
    output logic                            fbufRdTrig,
    output logic [dnRegPkg::bufAddrW-1:0]   fbufRdAddr,
    output logic [dnRegPkg::bufSizeW-1:0]   fbufRdSize,
    output logic                            fbufRdAuto,
    output logic                            ebufWrTrig,
    output logic [dnRegPkg::bufAddrW-1:0]   ebufWrAddr,
    output logic [dnRegPkg::bufSizeW-1:0]   ebufWrSize,
    output logic [dnRegPkg::regDataW-1:0]   rdWord
);

    logic                       chanHit;     // mapped access for this channel
    logic                       fbufWr;
    logic                       ebufWr;
    logic                       ctlWord;
    logic [dnRegPkg::dcntW-1:0] dcntQ;

    assign chanHit = acc.addrHit && (acc.chanSel == 1'(chanId));
    assign fbufWr  = acc.wrEn && chanHit && !acc.ebufSel;
    assign ebufWr  = acc.wrEn && chanHit && acc.ebufSel;
    assign ctlWord = (acc.wordIdx == dnRegPkg::ctlIdx);

    // ==============================
    // full-buffer read group
    // ==============================
    always_ff @(posedge PCIE_CLK or posedge PCIE_RST) begin
        if (PCIE_RST) begin
            fbufRdAddr <= '0;
            fbufRdSize <= '0;
            fbufRdAuto <= 1'b0;
        end else if (fbufWr) begin
            case (acc.wordIdx)
                dnRegPkg::addrLoIdx: begin
                    fbufRdAddr[dnRegPkg::regDataW-1:0] <= acc.wrWord;
                end
                dnRegPkg::addrHiIdx: begin
                    fbufRdAddr[dnRegPkg::bufAddrW-1:dnRegPkg::regDataW] <= acc.wrWord;
                end
                dnRegPkg::ctlIdx: begin
                    fbufRdSize <= acc.wrWord.fbuf.size;
                    fbufRdAuto <= acc.wrWord.fbuf.autoFlag;
                end
                default: begin
                    fbufRdAuto <= fbufRdAuto;   // count word is read only
                end
            endcase
        end
    end

    // ==============================
    // empty-buffer write group
    // ==============================
    always_ff @(posedge PCIE_CLK or posedge PCIE_RST) begin
        if (PCIE_RST) begin
            ebufWrAddr <= '0;
            ebufWrSize <= '0;
        end else if (ebufWr) begin
            case (acc.wordIdx)
                dnRegPkg::addrLoIdx: begin
                    ebufWrAddr[dnRegPkg::regDataW-1:0] <= acc.wrWord;
                end
                dnRegPkg::addrHiIdx: begin
                    ebufWrAddr[dnRegPkg::bufAddrW-1:dnRegPkg::regDataW] <= acc.wrWord;
                end
                default: begin
                    ebufWrSize <= acc.wrWord.ebuf.size;   // only ctlIdx reaches here
                end
            endcase
        end
    end

    // one-cycle pulses, in step with the write ack
    always_ff @(posedge PCIE_CLK or posedge PCIE_RST) begin
        if (PCIE_RST) begin
            fbufRdReq  <= 1'b0;
            fbufRdTrig <= 1'b0;
            ebufWrTrig <= 1'b0;
        end else begin
            fbufRdReq  <= fbufWr && ctlWord && acc.wrWord.fbuf.req;
            fbufRdTrig <= fbufWr && ctlWord && acc.wrWord.fbuf.trig;
            ebufWrTrig <= ebufWr && ctlWord && acc.wrWord.ebuf.trig;
        end
    end

    // count is free running in the buffer, so sample it every cycle
    always_ff @(posedge PCIE_CLK or posedge PCIE_RST) begin
        if (PCIE_RST) begin
            dcntQ <= '0;
        end else begin
            dcntQ <= fbufWrDcnt;
        end
    end

    // ==============================
    // readback
    // ==============================
    always_comb begin
        rdWord = '0;
        if (chanHit && !acc.ebufSel) begin
            case (acc.wordIdx)
                dnRegPkg::addrLoIdx: rdWord = fbufRdAddr[dnRegPkg::regDataW-1:0];
                dnRegPkg::addrHiIdx: rdWord = fbufRdAddr[dnRegPkg::bufAddrW-1:dnRegPkg::regDataW];
                dnRegPkg::ctlIdx:    rdWord = {fbufRdAuto, fbufRdSize};  // auto at bit 24
                default:             rdWord = {{(dnRegPkg::regDataW-dnRegPkg::dcntW){1'b0}}, dcntQ};
            endcase
        end else if (chanHit) begin
            case (acc.wordIdx)
                dnRegPkg::addrLoIdx: rdWord = ebufWrAddr[dnRegPkg::regDataW-1:0];
                dnRegPkg::addrHiIdx: rdWord = ebufWrAddr[dnRegPkg::bufAddrW-1:dnRegPkg::regDataW];
                default:             rdWord = {{(dnRegPkg::regDataW-dnRegPkg::bufSizeW){1'b0}}, ebufWrSize};
            endcase
        end
    end

endmodule

// ==== dnRegReadback.sv ====
`timescale 1ns/1ns

module dnRegReadback (
    input  logic                            PCIE_CLK,
    input  logic                            PCIE_RST,
    input  logic                            rdEn,
    input  logic [dnRegPkg::regDataW-1:0]   rdWord0,
    input  logic [dnRegPkg::regDataW-1:0]   rdWord1,
    output logic [dnRegPkg::regDataW-1:0]   regRdData,
    output logic                            regRdAck
);

    logic [4:0] rdEnDly;   // ack latency stages

    // ==============================
    // read data
    // ==============================
    // a channel not addressed drives zero, so OR merges cleanly
    always_ff @(posedge PCIE_CLK or posedge PCIE_RST) begin
        if (PCIE_RST) begin
            regRdData <= '0;
        end else begin
            regRdData <= rdWord0 | rdWord1;   // tracks the captured address
        end
    end

    // ==============================
    // read acknowledge
    // ==============================
    always_ff @(posedge PCIE_CLK or posedge PCIE_RST) begin
        if (PCIE_RST) begin
            rdEnDly <= '0;
        end else begin
            rdEnDly <= {rdEnDly[3:0], rdEn};
        end
    end

    assign regRdAck = rdEnDly[4];   // request + 6

endmodule

// ==== dnRegTop.sv ====
`timescale 1ns/1ns

module dnRegTop (
    input  logic                            PCIE_CLK,
    input  logic                            PCIE_RST,
    // host register port
    input  logic                            regWrReq,
    input  logic                            regRdReq,
    input  logic [dnRegPkg::regDataW-1:0]   regWrData,
    input  logic [dnRegPkg::regAddrW-1:0]   regOpAddr,
    output logic                            regWrAck,
    output logic                            regRdAck,
    output logic [dnRegPkg::regDataW-1:0]   regRdData,
    // channel 0
    output logic                            dn0FbufRdReq,
    output logic                            dn0FbufRdTrig,
    output logic [dnRegPkg::bufAddrW-1:0]   dn0FbufRdAddr,
    output logic [dnRegPkg::bufSizeW-1:0]   dn0FbufRdSize,
    output logic                            dn0FbufRdAuto,
    input  logic [dnRegPkg::dcntW-1:0]      dn0FbufWrDcnt,
    output logic                            dn0EbufWrTrig,
    output logic [dnRegPkg::bufAddrW-1:0]   dn0EbufWrAddr,
    output logic [dnRegPkg::bufSizeW-1:0]   dn0EbufWrSize,
    // channel 1
    output logic                            dn1FbufRdReq,
    output logic                            dn1FbufRdTrig,
    output logic [dnRegPkg::bufAddrW-1:0]   dn1FbufRdAddr,
    output logic [dnRegPkg::bufSizeW-1:0]   dn1FbufRdSize,
    output logic                            dn1FbufRdAuto,
    input  logic [dnRegPkg::dcntW-1:0]      dn1FbufWrDcnt,
    output logic                            dn1EbufWrTrig,
    output logic [dnRegPkg::bufAddrW-1:0]   dn1EbufWrAddr,
    output logic [dnRegPkg::bufSizeW-1:0]   dn1EbufWrSize
);

    logic [dnRegPkg::regDataW-1:0] rdWord0;
    logic [dnRegPkg::regDataW-1:0] rdWord1;

    regAccessIf acc ();

    dnRegFrontEnd i_frontEnd (
        .PCIE_CLK  (PCIE_CLK),
        .PCIE_RST  (PCIE_RST),
        .regWrReq  (regWrReq),
        .regRdReq  (regRdReq),
        .regWrData (regWrData),
        .regOpAddr (regOpAddr),
        .regWrAck  (regWrAck),
        .acc       (acc.frontEnd)
    );

    // ==============================
    // download channels
    // ==============================
    dnChannelRegs #(.chanId(0)) i_chan0 (
        .PCIE_CLK   (PCIE_CLK),
        .PCIE_RST   (PCIE_RST),
        .acc        (acc.channel),
        .fbufWrDcnt (dn0FbufWrDcnt),
        .fbufRdReq  (dn0FbufRdReq),
        .fbufRdTrig (dn0FbufRdTrig),
        .fbufRdAddr (dn0FbufRdAddr),
        .fbufRdSize (dn0FbufRdSize),
        .fbufRdAuto (dn0FbufRdAuto),
        .ebufWrTrig (dn0EbufWrTrig),
        .ebufWrAddr (dn0EbufWrAddr),
        .ebufWrSize (dn0EbufWrSize),
        .rdWord     (rdWord0)
    );

    dnChannelRegs #(.chanId(1)) i_chan1 (
        .PCIE_CLK   (PCIE_CLK),
        .PCIE_RST   (PCIE_RST),
        .acc        (acc.channel),
        .fbufWrDcnt (dn1FbufWrDcnt),
        .fbufRdReq  (dn1FbufRdReq),
        .fbufRdTrig (dn1FbufRdTrig),
        .fbufRdAddr (dn1FbufRdAddr),
        .fbufRdSize (dn1FbufRdSize),
        .fbufRdAuto (dn1FbufRdAuto),
        .ebufWrTrig (dn1EbufWrTrig),
        .ebufWrAddr (dn1EbufWrAddr),
        .ebufWrSize (dn1EbufWrSize),
        .rdWord     (rdWord1)
    );

    dnRegReadback i_readback (
        .PCIE_CLK  (PCIE_CLK),
        .PCIE_RST  (PCIE_RST),
        .rdEn      (acc.rdEn),
        .rdWord0   (rdWord0),
        .rdWord1   (rdWord1),
        .regRdData (regRdData),
        .regRdAck  (regRdAck)
    );

endmodule

// ==== dnReg_chk.sv ====
`timescale 1ns/1ns

module dnRegChk (
    input logic       PCIE_CLK,
    input logic       PCIE_RST,
    input logic       regWrAck,
    input logic       regRdAck,
    input logic [5:0] pulses      // trig and req outputs of both channels
);

    int assertFails = 0;          // read by the testbench at the end

    // ==============================
    // pulse shape
    // ==============================
    for (genvar i = 0; i < 6; i++) begin : gPulse
        aOneCycle: assert property (@(posedge PCIE_CLK) disable iff (PCIE_RST)
            pulses[i] |=> !pulses[i])
            else begin
                assertFails++;
                $error("pulse %0d stayed high for more than one cycle", i);
            end
    end

    aWithAck: assert property (@(posedge PCIE_CLK) disable iff (PCIE_RST)
        (|pulses) |-> regWrAck)
        else begin
            assertFails++;
            $error("pulse %b without a write acknowledge", pulses);
        end

    // host port never sees both acks at once
    aAckExcl: assert property (@(posedge PCIE_CLK) disable iff (PCIE_RST)
        !(regWrAck && regRdAck))
        else begin
            assertFails++;
            $error("write and read acknowledge high in the same cycle");
        end

endmodule

bind dnRegTop dnRegChk i_chk (
    .PCIE_CLK (PCIE_CLK),
    .PCIE_RST (PCIE_RST),
    .regWrAck (regWrAck),
    .regRdAck (regRdAck),
    .pulses   ({dn1EbufWrTrig, dn1FbufRdTrig, dn1FbufRdReq,
                dn0EbufWrTrig, dn0FbufRdTrig, dn0FbufRdReq})
);

// ==== tbDnRegMonitor.sv ====
`timescale 1ns/1ns

module tbDnRegMonitor (
    input  logic                                PCIE_CLK,
    // DUT outputs
    input  logic                                regWrAck,
    input  logic                                regRdAck,
    input  logic [dnRegPkg::regDataW-1:0]       regRdData,
    input  logic [1:0]                          fRdReq,
    input  logic [1:0]                          fRdTrig,
    input  logic [1:0]                          fRdAuto,
    input  logic [1:0]                          eWrTrig,
    input  logic [1:0][dnRegPkg::bufAddrW-1:0]  fRdAddr,
    input  logic [1:0][dnRegPkg::bufSizeW-1:0]  fRdSize,
    input  logic [1:0][dnRegPkg::bufAddrW-1:0]  eWrAddr,
    input  logic [1:0][dnRegPkg::bufSizeW-1:0]  eWrSize,
    // model expectations
    input  logic                                expWrAck,
    input  logic                                expRdAck,
    input  logic                                rdCheck,    // regRdData valid
    input  logic [dnRegPkg::regDataW-1:0]       expRdData,
    input  logic [1:0]                          expFReq,
    input  logic [1:0]                          expFTrig,
    input  logic [1:0]                          expFAuto,
    input  logic [1:0]                          expETrig,
    input  logic [1:0][dnRegPkg::bufAddrW-1:0]  expFAddr,
    input  logic [1:0][dnRegPkg::bufSizeW-1:0]  expFSize,
    input  logic [1:0][dnRegPkg::bufAddrW-1:0]  expEAddr,
    input  logic [1:0][dnRegPkg::bufSizeW-1:0]  expESize,
    output int                                  errCount
);

    string testName;              // set by the testbench top

    initial begin
        errCount = 0;
        testName = "reset";
    end

    task automatic compareVal(input string what, input logic [63:0] expVal,
                              input logic [63:0] actVal);
        if (actVal !== expVal) begin
            errCount++;
            $display("** Error [%s] %s: expected 0x%0h, actual 0x%0h",
                     testName, what, expVal, actVal);
        end
    endtask

    // ==============================
    // compare at the falling edge
    // ==============================
    always @(negedge PCIE_CLK) begin
        compareVal("regWrAck", expWrAck, regWrAck);
        compareVal("regRdAck", expRdAck, regRdAck);
        if (rdCheck) begin
            compareVal("regRdData", expRdData, regRdData);
        end
        for (int ch = 0; ch < 2; ch++) begin
            compareVal($sformatf("dn%0dFbufRdReq", ch), expFReq[ch], fRdReq[ch]);
            compareVal($sformatf("dn%0dFbufRdTrig", ch), expFTrig[ch], fRdTrig[ch]);
            compareVal($sformatf("dn%0dFbufRdAuto", ch), expFAuto[ch], fRdAuto[ch]);
            compareVal($sformatf("dn%0dFbufRdAddr", ch), expFAddr[ch], fRdAddr[ch]);
            compareVal($sformatf("dn%0dFbufRdSize", ch), expFSize[ch], fRdSize[ch]);
            compareVal($sformatf("dn%0dEbufWrTrig", ch), expETrig[ch], eWrTrig[ch]);
            compareVal($sformatf("dn%0dEbufWrAddr", ch), expEAddr[ch], eWrAddr[ch]);
            compareVal($sformatf("dn%0dEbufWrSize", ch), expESize[ch], eWrSize[ch]);
        end
    end

endmodule

// ==== tbDnReg.sv ====
`timescale 1ns/1ns

module tbDnReg;

    localparam int numRand    = 200;                          // write/read pairs
    localparam int numDcnt    = 16;                           // count read rounds
    localparam int numTxn     = 32 + 2 * numRand + 2 * numDcnt;
    localparam int watchdogNs = numTxn * 10 * 4 + 1000;

    logic                          PCIE_CLK;
    logic                          PCIE_RST;
    logic                          regWrReq;
    logic                          regRdReq;
    logic [dnRegPkg::regDataW-1:0] regWrData;
    logic [dnRegPkg::regAddrW-1:0] regOpAddr;
    logic [dnRegPkg::dcntW-1:0]    dn0FbufWrDcnt;
    logic [dnRegPkg::dcntW-1:0]    dn1FbufWrDcnt;
    wire                           regWrAck;
    wire                           regRdAck;
    wire  [dnRegPkg::regDataW-1:0] regRdData;
    wire                           dn0FbufRdReq, dn1FbufRdReq;
    wire                           dn0FbufRdTrig, dn1FbufRdTrig;
    wire                           dn0FbufRdAuto, dn1FbufRdAuto;
    wire                           dn0EbufWrTrig, dn1EbufWrTrig;
    wire  [dnRegPkg::bufAddrW-1:0] dn0FbufRdAddr, dn1FbufRdAddr;
    wire  [dnRegPkg::bufAddrW-1:0] dn0EbufWrAddr, dn1EbufWrAddr;
    wire  [dnRegPkg::bufSizeW-1:0] dn0FbufRdSize, dn1FbufRdSize;
    wire  [dnRegPkg::bufSizeW-1:0] dn0EbufWrSize, dn1EbufWrSize;

    // reference model, one entry per channel
    logic [1:0][63:0]              expFAddr, expEAddr;
    logic [1:0][23:0]              expFSize, expESize;
    logic [1:0]                    expFAuto, expFReq, expFTrig, expETrig;
    logic                          expWrAck, expRdAck, rdCheck;
    logic [31:0]                   expRdData;
    logic [31:0]                   lfsrState;
    int                            monErrors;

    dnRegTop i_dnRegTop (.*);

    tbDnRegMonitor i_monitor (
        .fRdReq   ({dn1FbufRdReq, dn0FbufRdReq}),
        .fRdTrig  ({dn1FbufRdTrig, dn0FbufRdTrig}),
        .fRdAuto  ({dn1FbufRdAuto, dn0FbufRdAuto}),
        .eWrTrig  ({dn1EbufWrTrig, dn0EbufWrTrig}),
        .fRdAddr  ({dn1FbufRdAddr, dn0FbufRdAddr}),
        .fRdSize  ({dn1FbufRdSize, dn0FbufRdSize}),
        .eWrAddr  ({dn1EbufWrAddr, dn0EbufWrAddr}),
        .eWrSize  ({dn1EbufWrSize, dn0EbufWrSize}),
        .errCount (monErrors),
        .*
    );

    always #2 PCIE_CLK = ~PCIE_CLK;

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};     // taps 32, 22, 2, 1
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic logic [15:0] locAddr(input logic ch, input logic eb, input logic [1:0] idx);
        logic [15:0] a;
        a = '0;
        a[dnRegPkg::chanBit] = ch;
        a[dnRegPkg::ebufBit] = eb;
        a[dnRegPkg::wordIdxLsb +: dnRegPkg::wordIdxW] = idx;
        return a;
    endfunction

    function automatic logic mapped(input logic [15:0] a);
        logic [15:0] fields;
        fields = locAddr(1'b1, 1'b1, 2'b11);                  // location select bits
        return ((a & ~fields) == '0) && !(a[dnRegPkg::ebufBit] && (a[4:3] == 2'd3));
    endfunction

    function automatic logic [31:0] modelWord(input logic [15:0] a);
        logic ch;
        ch = a[dnRegPkg::chanBit];
        if (!mapped(a)) begin
            return '0;
        end
        if (a[dnRegPkg::ebufBit]) begin
            case (a[4:3])
                2'd0:    return expEAddr[ch][31:0];
                2'd1:    return expEAddr[ch][63:32];
                default: return {8'h00, expESize[ch]};
            endcase
        end
        case (a[4:3])
            2'd0:    return expFAddr[ch][31:0];
            2'd1:    return expFAddr[ch][63:32];
            2'd2:    return {7'h00, expFAuto[ch], expFSize[ch]};   // auto at bit 24
            default: return {23'h0, ch ? dn1FbufWrDcnt : dn0FbufWrDcnt};
        endcase
    endfunction

    function automatic logic [15:0] randAddr();
        logic [15:0] a;
        logic [3:0]  pos;
        a = locAddr(randBits(1), 1'b0, 2'd0);
        a[dnRegPkg::ebufBit] = randBits(1);
        a[4:3] = randBits(2);
        if (randBits(2) == 0) begin
            pos = randBits(4);
            a[pos] = 1'b1;                                    // mostly lands unmapped
        end
        return a;
    endfunction

    task automatic nextCycle();
        @(posedge PCIE_CLK);
        #1;
    endtask

    // ==============================
    // host transactions
    // ==============================
    task automatic doWrite(input logic [15:0] a, input logic [31:0] d);
        logic ch;
        ch = a[dnRegPkg::chanBit];
        regWrReq  = 1'b1;
        regOpAddr = a;
        regWrData = d;
        nextCycle();
        regWrReq = 1'b0;
        nextCycle();                                          // request + 2
        expWrAck = 1'b1;
        if (mapped(a) && !a[dnRegPkg::ebufBit]) begin
            case (a[4:3])
                2'd0: expFAddr[ch][31:0]  = d;
                2'd1: expFAddr[ch][63:32] = d;
                2'd2: begin
                    expFSize[ch] = d[23:0];
                    expFAuto[ch] = d[dnRegPkg::autoBit];
                    expFReq[ch]  = d[dnRegPkg::reqBit];
                    expFTrig[ch] = d[dnRegPkg::trigBit];
                end
                default: ;                                    // count is read only
            endcase
        end else if (mapped(a)) begin
            case (a[4:3])
                2'd0: expEAddr[ch][31:0]  = d;
                2'd1: expEAddr[ch][63:32] = d;
                default: begin
                    expESize[ch] = d[23:0];
                    expETrig[ch] = d[dnRegPkg::trigBit];
                end
            endcase
        end
        nextCycle();
        expWrAck = 1'b0;
        expFReq  = '0;
        expFTrig = '0;
        expETrig = '0;
    endtask

    task automatic doRead(input logic [15:0] a);
        dn0FbufWrDcnt = randBits(9);                          // held until the next read
        dn1FbufWrDcnt = randBits(9);
        regRdReq  = 1'b1;
        regOpAddr = a;
        nextCycle();
        regRdReq = 1'b0;
        nextCycle();                                          // request + 2
        expRdData = modelWord(a);
        rdCheck   = 1'b1;
        repeat (4) nextCycle();
        expRdAck = 1'b1;                                      // request + 6
        nextCycle();
        expRdAck = 1'b0;
        rdCheck  = 1'b0;
    endtask

    task automatic printCounts();
        $display("Errors: %0d value mismatches, %0d assertion failures",
                 monErrors, i_dnRegTop.i_chk.assertFails);
    endtask

    initial begin
        logic [15:0] addr;
        PCIE_CLK      = 1'b0;
        PCIE_RST      = 1'b1;
        regWrReq      = 1'b0;
        regRdReq      = 1'b0;
        regWrData     = '0;
        regOpAddr     = '0;
        dn0FbufWrDcnt = '0;
        dn1FbufWrDcnt = '0;
        {expFAddr, expEAddr, expFSize, expESize} = '0;
        {expFAuto, expFReq, expFTrig, expETrig}  = '0;
        {expWrAck, expRdAck, rdCheck, expRdData} = '0;
        rdCheck       = 1'b1;                                 // read data is zero out of reset
        lfsrState = 32'hca71_fee9;
        repeat (10) @(posedge PCIE_CLK);
        #1;
        PCIE_RST = 1'b0;
        repeat (3) nextCycle();
        rdCheck = 1'b0;

        // every location once, the two unmapped ebuf count words included
        i_monitor.testName = "sweep";
        for (int loc = 0; loc < 16; loc++) begin
            addr = locAddr(loc[3], loc[2], loc[1:0]);
            doWrite(addr, randBits(32));
            doRead(addr);
        end
        i_monitor.testName = "random";
        for (int n = 0; n < numRand; n++) begin
            addr = randAddr();
            doWrite(addr, randBits(32));
            doRead(addr);
        end
        i_monitor.testName = "dcnt";
        for (int n = 0; n < numDcnt; n++) begin
            doRead(locAddr(1'b0, 1'b0, dnRegPkg::dcntIdx));
            doRead(locAddr(1'b1, 1'b0, dnRegPkg::dcntIdx));
        end
        repeat (4) nextCycle();

        printCounts();
        if (monErrors == 0 && i_dnRegTop.i_chk.assertFails == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // ==============================
    // watchdog
    // ==============================
    initial begin
        #(watchdogNs);
        $display("Run did not finish within %0d ns and was stopped", watchdogNs);
        printCounts();
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== tb.f ====
dnRegPkg.sv
regAccessIf.sv
dnRegFrontEnd.sv
dnChannelRegs.sv
dnRegReadback.sv
dnRegTop.sv
dnReg_chk.sv
tbDnRegMonitor.sv
tbDnReg.sv
